//--- source/msg_pkg.sv
package msg_pkg;

  localparam int XB_SIZE = 32; // pc link word width
  typedef logic [XB_SIZE-1:0] pc_word_t;

  // pixel message layout, only the sync bits survive
  typedef struct packed {
    logic [XB_SIZE-7:0] rsvd;  // bits 31..6, pixel data not used here
    logic               fval;  // bit 5
    logic               lval;  // bit 4
    logic [1:0]         spare; // bits 3..2
    logic [1:0]         tag;   // bits 1..0, zero for pixel
  } pix_word_t;

  localparam int DRAM_GROUP_WORDS = 16; // non-pixel words per dram group
  localparam int GROUP_CNT_W = $clog2(DRAM_GROUP_WORDS);

  // camera geometry counters
  localparam int COL_W = 11;
  localparam int ROW_W = 12;
  localparam int FRAME_W = 20;
  localparam int PIXELS_PER_CLK = 2; // two pixels per stream word

  typedef struct packed {
    logic [ROW_W-1:0]   row;
    logic [COL_W-1:0]   col;
    logic [FRAME_W-1:0] frame;
  } pix_pos_t; // 43 bits

endpackage

//--- source/dram_pkg.sv
package dram_pkg;

  localparam int APP_DATA_WIDTH = 64; // cut down from the board width
  localparam int ADDR_WIDTH = 27;
  localparam logic [ADDR_WIDTH-1:0] ADDR_INC = 27'd8; // bl8 step
  localparam int WORDS_PER_BURST = 4; // 2 beats x 2 words
  localparam logic [1:0] END_MARK = 2'b01; // low bits of beat two

  // command channel of the dram user interface
  typedef struct packed {
    logic                  en;
    logic                  read; // 0 write, 1 read
    logic [ADDR_WIDTH-1:0] addr;
  } app_cmd_t;

  // write data channel
  typedef struct packed {
    logic                      wren;
    logic                      last; // end of burst, wdf_end on the controller
    logic [APP_DATA_WIDTH-1:0] data;
  } app_wr_t;

  // everything coming back from the controller
  typedef struct packed {
    logic                      rdy;
    logic                      wdf_rdy;
    logic                      rd_valid;
    logic [APP_DATA_WIDTH-1:0] rd_data;
  } app_rsp_t;

  typedef enum logic [2:0] {
    ST_ERROR,
    ST_MSG_WAIT,
    ST_WR_WAIT,
    ST_WR1,
    ST_WR2,
    ST_READING,
    ST_THROTTLED,
    ST_INTERFRAME
  } dram_state_t;

  // coefficient word formats on read return
  localparam int PATCH_CONF_W = 43; // starts at bit 4
  localparam int ROW_CONF_W = 56;   // starts at bit 8
  localparam int PATCH_ROWS = 12;

  typedef struct packed {
    logic                    patch_valid;
    logic [PATCH_ROWS-1:0]   row_valid; // one hot by patch row
    logic [PATCH_CONF_W-1:0] patch_conf;
    logic [ROW_CONF_W-1:0]   row_conf;
  } coef_strobe_t;

endpackage

//--- source/msg_fifo.sv
`timescale 1ns/1ns

module msg_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16
) (
  input  logic     CLK,
  input  logic     fds_val,
  input  logic     wren,
  input  payload_t din,
  input  logic     rden,
  output payload_t dout,
  output logic     full,
  output logic     empty,
  output logic     overflow
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic do_wr, do_rd;

  assign full = count == CW'(DEPTH);
  assign empty = count == '0;
  assign do_wr = wren && !full;  // drop when full
  assign do_rd = rden && !empty; // pop on empty is ignored
  assign dout = mem[rd_ptr];     // fwft, head always visible

  // storage, no reset needed
  always_ff @(posedge CLK) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= wren && full; // one cycle flag
      if (do_wr) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

endmodule

//--- source/pc_msg_router.sv
`timescale 1ns/1ns

module pc_msg_router (
  input  logic              CLK,
  input  logic              fds_val,
  input  logic              pc_msg_pending,
  input  msg_pkg::pc_word_t pc_msg,
  input  logic              pixel_full,
  input  logic              dram_full,
  output logic              pc_msg_ack,
  output logic              pixel_wren,
  output logic              dram_wren,
  output msg_pkg::pc_word_t msg_d
);
  msg_pkg::pix_word_t pix;
  logic [msg_pkg::GROUP_CNT_W-1:0] grp_cnt; // position inside a dram group
  logic is_pixel;

  assign pix = pc_msg;
  // only take a word when either queue could hold it
  assign pc_msg_ack = pc_msg_pending && !pixel_full && !dram_full;
  // mid-group words are dram data whatever their tag says
  assign is_pixel = pix.tag == 2'b00 && grp_cnt == '0;

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      grp_cnt <= '0;
      pixel_wren <= 1'b0;
      dram_wren <= 1'b0;
    end else begin
      pixel_wren <= pc_msg_ack && is_pixel;  // lines up with msg_d
      dram_wren <= pc_msg_ack && !is_pixel;
      if (pc_msg_ack && !is_pixel) grp_cnt <= grp_cnt + 1'b1; // wraps at 16
    end
  end

  // word held one cycle for the queue write
  always_ff @(posedge CLK) begin
    if (pc_msg_ack) msg_d <= pc_msg;
  end

endmodule

//--- source/dram_coef_ctrl.sv
`timescale 1ns/1ns

module dram_coef_ctrl #(
  parameter logic [dram_pkg::ADDR_WIDTH-1:0] START_ADDR = '0
) (
  input  logic               CLK,
  input  logic               fds_val,
  input  logic               dram_empty,
  input  msg_pkg::pc_word_t  dram_msg,
  output logic               dram_pop,
  input  dram_pkg::app_rsp_t app_rsp,
  output dram_pkg::app_cmd_t app_cmd,
  output dram_pkg::app_wr_t  app_wr,
  input  logic               coef_high,
  input  logic               frame_gap,
  output logic               dram_error
);
  localparam int XB = msg_pkg::XB_SIZE;
  localparam int AD_W = dram_pkg::APP_DATA_WIDTH;
  localparam int BURST_W = dram_pkg::WORDS_PER_BURST * XB; // two beats
  localparam int IDX_W = $clog2(dram_pkg::WORDS_PER_BURST);

  dram_pkg::dram_state_t state;
  logic [BURST_W-1:0] burst; // word 0 in the low bits
  logic [IDX_W-1:0] word_idx;
  logic [dram_pkg::ADDR_WIDTH-1:0] addr, end_addr;
  logic cmd_en, cmd_read;
  logic wr_wren, wr_last;
  logic [AD_W-1:0] wr_data;
  logic burst_full, wr_accept, last_rd;

  assign dram_pop = !dram_empty && state == dram_pkg::ST_MSG_WAIT;
  assign burst_full = word_idx == IDX_W'(dram_pkg::WORDS_PER_BURST - 1);
  assign wr_accept = app_rsp.rdy && app_rsp.wdf_rdy; // cmd and data side both free
  assign last_rd = app_rsp.rdy && addr == end_addr;

  assign app_cmd = '{en: cmd_en, read: cmd_read, addr: addr};
  assign app_wr = '{wren: wr_wren, last: wr_last, data: wr_data};
  assign dram_error = state == dram_pkg::ST_ERROR;

  // burst packing and beat data
  always_ff @(posedge CLK) begin
    if (dram_pop) burst[word_idx*XB +: XB] <= dram_msg;
    if (state == dram_pkg::ST_WR_WAIT && wr_accept)
      wr_data <= burst[0 +: AD_W]; // words 0,1
    else if (state == dram_pkg::ST_WR1 && app_rsp.wdf_rdy)
      wr_data <= burst[AD_W +: AD_W]; // words 2,3
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state <= dram_pkg::ST_MSG_WAIT;
      word_idx <= '0;
      addr <= START_ADDR;
      end_addr <= START_ADDR;
      cmd_en <= 1'b0;
      cmd_read <= 1'b0;
      wr_wren <= 1'b0;
      wr_last <= 1'b1; // idles high like the mig port
    end else begin
      case (state)
        dram_pkg::ST_ERROR: begin
          cmd_en <= 1'b0; // parked until reset
        end
        dram_pkg::ST_MSG_WAIT: begin
          if (dram_pop) begin
            word_idx <= word_idx + 1'b1; // wraps back to 0 per burst
            if (burst_full) begin
              cmd_en <= 1'b1; // write command with current addr
              state <= dram_pkg::ST_WR_WAIT;
            end
          end
        end
        dram_pkg::ST_WR_WAIT: begin
          if (wr_accept) begin
            addr <= addr + dram_pkg::ADDR_INC; // next burst
            cmd_en <= 1'b0;
            wr_wren <= 1'b1; // beat one out
            wr_last <= 1'b0;
            state <= dram_pkg::ST_WR1;
          end
        end
        dram_pkg::ST_WR1: begin
          if (app_rsp.wdf_rdy) begin
            wr_last <= 1'b1; // beat two closes the burst
            state <= dram_pkg::ST_WR2;
          end
        end
        dram_pkg::ST_WR2: begin
          wr_wren <= 1'b0;
          if (!app_rsp.wdf_rdy) begin
            state <= dram_pkg::ST_ERROR; // beat two not taken
          // end marker sits in word 2, the low half of beat two
          end else if (wr_data[1:0] == dram_pkg::END_MARK) begin
            end_addr <= addr - dram_pkg::ADDR_INC; // addr already moved on
            addr <= START_ADDR;
            cmd_read <= 1'b1;
            cmd_en <= 1'b1;
            state <= dram_pkg::ST_READING;
          end else begin
            state <= dram_pkg::ST_MSG_WAIT;
          end
        end
        dram_pkg::ST_READING: begin
          if (app_rsp.rdy) addr <= addr + dram_pkg::ADDR_INC; // read taken
          if (last_rd) begin
            cmd_en <= 1'b0;
            state <= dram_pkg::ST_INTERFRAME;
          end else if (coef_high) begin
            cmd_en <= 1'b0; // consumer backed up
            state <= dram_pkg::ST_THROTTLED;
          end
        end
        dram_pkg::ST_THROTTLED: begin
          if (!coef_high) begin
            cmd_en <= 1'b1;
            state <= dram_pkg::ST_READING;
          end
        end
        dram_pkg::ST_INTERFRAME: begin
          if (frame_gap) begin // replay for the next frame
            addr <= START_ADDR;
            cmd_en <= 1'b1;
            state <= dram_pkg::ST_READING;
          end
        end
        default: state <= dram_pkg::ST_ERROR;
      endcase
    end
  end

endmodule

//--- source/coef_steer.sv
`timescale 1ns/1ns

module coef_steer (
  input  logic                   CLK,
  input  logic                   fds_val,
  input  dram_pkg::app_rsp_t     app_rsp,
  output dram_pkg::coef_strobe_t coef
);
  logic patch_valid;
  logic [dram_pkg::PATCH_ROWS-1:0] row_valid;
  logic [dram_pkg::PATCH_CONF_W-1:0] patch_conf;
  logic [dram_pkg::ROW_CONF_W-1:0] row_conf;

  assign coef = '{patch_valid: patch_valid, row_valid: row_valid,
                  patch_conf: patch_conf, row_conf: row_conf};

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      patch_valid <= 1'b0;
      row_valid <= '0;
    end else begin
      // bit 0 picks patch vs row word
      patch_valid <= app_rsp.rd_valid && !app_rsp.rd_data[0];
      for (int i = 0; i < dram_pkg::PATCH_ROWS; i++)
        row_valid[i] <= app_rsp.rd_valid && app_rsp.rd_data[0]
                        && app_rsp.rd_data[7:4] == 4'(i); // row index
    end
  end

  // payloads follow the data, strobes say which one counts
  always_ff @(posedge CLK) begin
    patch_conf <= app_rsp.rd_data[4 +: dram_pkg::PATCH_CONF_W];
    row_conf <= app_rsp.rd_data[8 +: dram_pkg::ROW_CONF_W];
  end

endmodule

//--- source/pixel_timing.sv
`timescale 1ns/1ns

module pixel_timing (
  input  logic              CLK,
  input  logic              fds_val,
  input  logic              pixel_empty,
  input  msg_pkg::pc_word_t pixel_msg,
  output logic              pixel_pop,
  output logic              frame_gap,
  output msg_pkg::pix_pos_t pix_pos
);
  typedef enum logic [1:0] {
    PX_STANDBY,
    PX_INTRALINE,
    PX_INTERLINE,
    PX_INTERFRAME
  } px_state_t;

  px_state_t state;
  msg_pkg::pix_word_t pix;
  logic [msg_pkg::ROW_W-1:0] row;
  logic [msg_pkg::COL_W-1:0] col;
  logic [msg_pkg::FRAME_W-1:0] frame;

  assign pix = pixel_msg;
  assign pixel_pop = !pixel_empty; // stream can't be stalled
  assign frame_gap = pixel_pop && !pix.fval;
  assign pix_pos = '{row: row, col: col, frame: frame};

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state <= PX_STANDBY;
      row <= '0;
      col <= '0;
      frame <= '0;
    end else if (pixel_pop) begin
      case (state)
        PX_STANDBY: begin
          if (!pix.fval) begin // sync to the first gap
            row <= '0;
            col <= '0;
            frame <= '0;
            state <= PX_INTERFRAME;
          end
        end
        PX_INTRALINE: begin
          if (pix.lval) begin
            col <= col + msg_pkg::COL_W'(msg_pkg::PIXELS_PER_CLK);
          end else if (pix.fval) begin
            row <= row + 1'b1; // line done, frame continues
            state <= PX_INTERLINE;
          end else begin
            frame <= frame + 1'b1;
            state <= PX_INTERFRAME;
          end
        end
        PX_INTERLINE: begin
          if (!pix.fval) begin // fval fell after the last line
            frame <= frame + 1'b1;
            state <= PX_INTERFRAME;
          end else if (pix.lval) begin
            col <= '0;
            state <= PX_INTRALINE;
          end
        end
        default: begin // interframe
          if (pix.lval) begin
            row <= '0;
            col <= '0;
            state <= PX_INTRALINE;
          end
        end
      endcase
    end
  end

endmodule

//--- source/pattern_top.sv
`timescale 1ns/1ns

module pattern_top #(
  parameter int                              XB_DEPTH   = 16,
  parameter logic [dram_pkg::ADDR_WIDTH-1:0] START_ADDR = '0
) (
  input  logic                   CLK,
  input  logic                   fds_val,
  input  logic                   pc_msg_pending,
  input  msg_pkg::pc_word_t      pc_msg,
  output logic                   pc_msg_ack,
  output dram_pkg::app_cmd_t     app_cmd,
  output dram_pkg::app_wr_t      app_wr,
  input  dram_pkg::app_rsp_t     app_rsp,
  input  logic                   coef_high,
  output dram_pkg::coef_strobe_t coef,
  output msg_pkg::pix_pos_t      pix_pos,
  output logic                   error
);
  msg_pkg::pc_word_t msg_d, dram_msg, pixel_msg;
  logic pixel_wren, dram_wren;
  logic pixel_full, dram_full, pixel_empty, dram_empty;
  logic dram_pop, pixel_pop, pixel_ovf;
  logic frame_gap, dram_error;
  logic pix_ovf_seen; // sticky

  pc_msg_router u_router (
    .CLK(CLK), .fds_val(fds_val),
    .pc_msg_pending(pc_msg_pending), .pc_msg(pc_msg),
    .pixel_full(pixel_full), .dram_full(dram_full),
    .pc_msg_ack(pc_msg_ack), .pixel_wren(pixel_wren), .dram_wren(dram_wren),
    .msg_d(msg_d)
  );

  // coefficient words toward dram
  msg_fifo #(.payload_t(msg_pkg::pc_word_t), .DEPTH(XB_DEPTH)) u_dram_q (
    .CLK(CLK), .fds_val(fds_val),
    .wren(dram_wren), .din(msg_d), .rden(dram_pop), .dout(dram_msg),
    .full(dram_full), .empty(dram_empty), .overflow()
  );

  // camera stream, one word per entry
  msg_fifo #(.payload_t(msg_pkg::pc_word_t), .DEPTH(XB_DEPTH)) u_pixel_q (
    .CLK(CLK), .fds_val(fds_val),
    .wren(pixel_wren), .din(msg_d), .rden(pixel_pop), .dout(pixel_msg),
    .full(pixel_full), .empty(pixel_empty), .overflow(pixel_ovf)
  );

  dram_coef_ctrl #(.START_ADDR(START_ADDR)) u_dram_ctrl (
    .CLK(CLK), .fds_val(fds_val),
    .dram_empty(dram_empty), .dram_msg(dram_msg), .dram_pop(dram_pop),
    .app_rsp(app_rsp), .app_cmd(app_cmd), .app_wr(app_wr),
    .coef_high(coef_high), .frame_gap(frame_gap), .dram_error(dram_error)
  );

  coef_steer u_steer (
    .CLK(CLK), .fds_val(fds_val), .app_rsp(app_rsp), .coef(coef)
  );

  pixel_timing u_timing (
    .CLK(CLK), .fds_val(fds_val),
    .pixel_empty(pixel_empty), .pixel_msg(pixel_msg), .pixel_pop(pixel_pop),
    .frame_gap(frame_gap), .pix_pos(pix_pos)
  );

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) pix_ovf_seen <= 1'b0;
    else if (pixel_ovf) pix_ovf_seen <= 1'b1; // lost pixel, hold until reset
  end

  assign error = dram_error || pix_ovf_seen;

endmodule

//--- tb/pattern_assertions.sv
`timescale 1ns/1ns

module pattern_assertions (
  input logic                   CLK,
  input logic                   fds_val,
  input logic                   pc_msg_ack,
  input logic                   dram_full,
  input logic                   pixel_full,
  input dram_pkg::app_cmd_t     app_cmd,
  input dram_pkg::app_wr_t      app_wr,
  input dram_pkg::app_rsp_t     app_rsp,
  input logic                   coef_high,
  input dram_pkg::coef_strobe_t coef,
  input logic                   error
);
  localparam logic [dram_pkg::PATCH_ROWS-1:0] ROW0 = 1; // row 0 strobe
  int fail_cnt = 0; // summed into the testbench totals

  ack_when_full: assert property (@(posedge CLK) disable iff (fds_val)
    pc_msg_ack |-> !dram_full && !pixel_full)
    else begin
      $error("pc_msg_ack high while a queue is full");
      fail_cnt++;
    end

  // end idles high, drops only on beat one
  end_idle: assert property (@(posedge CLK) disable iff (fds_val)
    !app_wr.wren |-> app_wr.last)
    else begin
      $error("app_wr.end low outside a burst");
      fail_cnt++;
    end

  beat_two_follows: assert property (@(posedge CLK) disable iff (fds_val)
    app_wr.wren && !app_wr.last && app_rsp.wdf_rdy |=> app_wr.wren && app_wr.last)
    else begin
      $error("beat two with end high did not follow beat one");
      fail_cnt++;
    end

  beat_two_once: assert property (@(posedge CLK) disable iff (fds_val)
    app_wr.wren && app_wr.last |=> !app_wr.wren)
    else begin
      $error("burst runs past beat two");
      fail_cnt++;
    end

  throttle_drop: assert property (@(posedge CLK) disable iff (fds_val)
    app_cmd.read && app_cmd.en && coef_high |=> !app_cmd.en)
    else begin
      $error("read command stays up while coef_high is high");
      fail_cnt++;
    end

  // parked reads keep their address, en may only rise on a new frame
  throttle_hold: assert property (@(posedge CLK) disable iff (fds_val)
    app_cmd.read && !app_cmd.en && coef_high |=> app_cmd.en || $stable(app_cmd.addr))
    else begin
      $error("read address moved while throttled");
      fail_cnt++;
    end

  patch_decode: assert property (@(posedge CLK) disable iff (fds_val)
    app_rsp.rd_valid && !app_rsp.rd_data[0] |=> coef.patch_valid && coef.row_valid == '0
      && coef.patch_conf == $past(app_rsp.rd_data[4 +: dram_pkg::PATCH_CONF_W]))
    else begin
      $error("patch coefficient strobe or payload wrong");
      fail_cnt++;
    end

  row_decode: assert property (@(posedge CLK) disable iff (fds_val)
    app_rsp.rd_valid && app_rsp.rd_data[0] |=> !coef.patch_valid
      && coef.row_valid == (ROW0 << $past(app_rsp.rd_data[7:4]))
      && coef.row_conf == $past(app_rsp.rd_data[8 +: dram_pkg::ROW_CONF_W]))
    else begin
      $error("row coefficient strobe or payload wrong");
      fail_cnt++;
    end

  quiet_strobes: assert property (@(posedge CLK) disable iff (fds_val)
    !app_rsp.rd_valid |=> !coef.patch_valid && coef.row_valid == '0)
    else begin
      $error("coefficient strobe without returned data");
      fail_cnt++;
    end

  no_error: assert property (@(posedge CLK) disable iff (fds_val) !error)
    else begin
      $error("error output raised");
      fail_cnt++;
    end

endmodule

//--- tb/tb_dram_model.sv
`timescale 1ns/1ns

module tb_dram_model (
  input  logic               CLK,
  input  logic               fds_val,
  input  dram_pkg::app_cmd_t app_cmd,
  input  dram_pkg::app_wr_t  app_wr,
  output dram_pkg::app_rsp_t app_rsp
);
  localparam int AD_W = dram_pkg::APP_DATA_WIDTH;
  typedef logic [dram_pkg::ADDR_WIDTH-1:0] addr_t;

  logic [2*AD_W-1:0] mem [addr_t]; // one bl8 burst per address, beat two on top
  addr_t wr_pend[$]; // write commands still waiting for data
  addr_t wr_log[$];  // completed bursts in order
  addr_t rd_log[$];  // accepted reads in order
  addr_t rd_pend[$]; // reads not yet returned
  int rd_due[$];
  logic [AD_W-1:0] beat_one;
  logic second_beat;
  int cyc;
  int seed;

  initial begin
    seed = 21;
    cyc = 0;
    second_beat = 1'b0;
    app_rsp = '0;
    forever begin
      @(negedge CLK); // look at what the dut takes on the coming edge
      if (!fds_val) begin
        if (app_cmd.en && app_rsp.rdy) begin
          if (app_cmd.read) begin
            rd_log.push_back(app_cmd.addr);
            rd_pend.push_back(app_cmd.addr);
            rd_due.push_back(cyc + 2 + ($random(seed) & 3)); // few cycles of latency
          end else begin
            wr_pend.push_back(app_cmd.addr);
          end
        end
        if (app_wr.wren && app_rsp.wdf_rdy) begin
          if (!app_wr.last) begin
            beat_one = app_wr.data;
          end else if (wr_pend.size() > 0) begin
            mem[wr_pend[0]] = {app_wr.data, beat_one};
            wr_log.push_back(wr_pend.pop_front());
          end
        end
      end
      @(posedge CLK);
      #2;
      cyc++;
      if (fds_val) begin
        app_rsp = '0;
      end else begin
        app_rsp.rdy = ($random(seed) & 3) != 0; // busy about one cycle in four
        app_rsp.wdf_rdy = 1'b1;
        app_rsp.rd_valid = 1'b0;
        if (rd_pend.size() > 0 && cyc >= rd_due[0]) begin
          app_rsp.rd_valid = 1'b1;
          app_rsp.rd_data = second_beat ? mem[rd_pend[0]][AD_W +: AD_W]
                                        : mem[rd_pend[0]][0 +: AD_W];
          if (second_beat) begin
            void'(rd_pend.pop_front());
            void'(rd_due.pop_front());
          end
          second_beat = !second_beat;
        end
      end
    end
  end

endmodule

//--- tb/tb_pattern_top.sv
`timescale 1ns/1ns

module tb_pattern_top;
  typedef logic [dram_pkg::ADDR_WIDTH-1:0] addr_t;
  localparam addr_t START = 27'h40;
  localparam int LIMIT = 400; // cycles allowed per wait

  logic CLK;
  logic fds_val;
  logic pc_msg_pending;
  msg_pkg::pc_word_t pc_msg;
  logic pc_msg_ack;
  dram_pkg::app_cmd_t app_cmd;
  dram_pkg::app_wr_t app_wr;
  dram_pkg::app_rsp_t app_rsp;
  logic coef_high;
  dram_pkg::coef_strobe_t coef;
  msg_pkg::pix_pos_t pix_pos;
  logic error;

  msg_pkg::pc_word_t words [16]; // one dram group
  int seed;
  int errors, checks, tests, mark;

  pattern_top #(.XB_DEPTH(16), .START_ADDR(START)) u_dut (
    .CLK(CLK), .fds_val(fds_val),
    .pc_msg_pending(pc_msg_pending), .pc_msg(pc_msg), .pc_msg_ack(pc_msg_ack),
    .app_cmd(app_cmd), .app_wr(app_wr), .app_rsp(app_rsp),
    .coef_high(coef_high), .coef(coef), .pix_pos(pix_pos), .error(error)
  );

  tb_dram_model u_model (
    .CLK(CLK), .fds_val(fds_val), .app_cmd(app_cmd), .app_wr(app_wr), .app_rsp(app_rsp)
  );

  bind pattern_top pattern_assertions u_asrt (
    .CLK(CLK), .fds_val(fds_val), .pc_msg_ack(pc_msg_ack),
    .dram_full(dram_full), .pixel_full(pixel_full),
    .app_cmd(app_cmd), .app_wr(app_wr), .app_rsp(app_rsp),
    .coef_high(coef_high), .coef(coef), .error(error)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic int failures();
    return errors + u_dut.u_asrt.fail_cnt;
  endfunction

  function automatic msg_pkg::pc_word_t pixel(logic fval, logic lval);
    msg_pkg::pix_word_t p;
    p = '0; // tag zero
    p.fval = fval;
    p.lval = lval;
    return p;
  endfunction

  task automatic expect_eq(string name, logic [127:0] exp, logic [127:0] act);
    checks++;
    assert (exp === act)
    else begin
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic timed_out(string what);
    $display("gave up waiting for %s", what);
    errors++;
  endtask

  task automatic finish_test(string name);
    tests++;
    $display("test %-14s done, %0d failures", name, failures() - mark);
    mark = failures();
  endtask

  // hold the word until acked
  task automatic send_word(msg_pkg::pc_word_t w);
    int n;
    n = 0;
    pc_msg_pending = 1'b1;
    pc_msg = w;
    do begin
      @(negedge CLK);
      n++;
    end while (!pc_msg_ack && n < LIMIT);
    if (!pc_msg_ack) timed_out("pc_msg_ack");
    @(posedge CLK);
    #2;
    pc_msg_pending = 1'b0;
  endtask

  task automatic wait_cmd_en(logic lvl);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (app_cmd.en !== lvl && n < LIMIT);
    if (app_cmd.en !== lvl) timed_out("app_cmd.en");
    @(posedge CLK);
    #2;
  endtask

  task automatic wait_reads(int cnt);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (u_model.rd_log.size() < cnt && n < LIMIT);
    if (u_model.rd_log.size() < cnt) timed_out("dram reads");
    @(posedge CLK);
    #2;
  endtask

  task automatic wait_bursts(int cnt);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (u_model.wr_log.size() < cnt && n < LIMIT);
    if (u_model.wr_log.size() < cnt) timed_out("dram write bursts");
    @(posedge CLK);
    #2;
  endtask

  // queue empty and nothing in flight from the router
  task automatic wait_pixels_drained();
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!(u_dut.pixel_empty && !u_dut.pixel_wren) && n < LIMIT);
    if (!(u_dut.pixel_empty && !u_dut.pixel_wren)) timed_out("pixel queue to drain");
    @(posedge CLK);
    #2;
  endtask

  task automatic wait_dram_full();
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!u_dut.dram_full && n < LIMIT);
    if (!u_dut.dram_full) timed_out("dram queue to fill");
    @(posedge CLK);
    #2;
  endtask

  task automatic check_replay(int first);
    for (int i = 0; i < 4; i++)
      expect_eq($sformatf("replay read %0d", first + i), addr_t'(START + 8 * i),
                u_model.rd_log[first + i]);
  endtask

  initial begin
    int held;
    seed = 21;
    errors = 0;
    checks = 0;
    tests = 0;
    mark = 0;
    fds_val = 1'b1;
    pc_msg_pending = 1'b0;
    pc_msg = '0;
    coef_high = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
    fds_val = 1'b0;

    expect_eq("reset cmd en", 0, app_cmd.en);
    expect_eq("reset cmd read", 0, app_cmd.read);
    expect_eq("reset wren", 0, app_wr.wren);
    expect_eq("reset end", 1, app_wr.last);
    expect_eq("reset patch strobe", 0, coef.patch_valid);
    expect_eq("reset row strobe", 0, coef.row_valid);
    expect_eq("reset error", 0, error);
    finish_test("reset");

    for (int i = 0; i < 16; i++) words[i] = $random(seed);
    words[0][1:0] = 2'b10; // nonzero tag opens the group, patch word
    for (int i = 2; i < 12; i += 4)
      if (words[i][1:0] == dram_pkg::END_MARK) words[i][1:0] = 2'b11;
    words[14][1:0] = dram_pkg::END_MARK; // word 2 of the last burst
    words[14][7:4] = 4'd3; // row word for patch row 3
    for (int i = 0; i < 16; i++) send_word(words[i]);
    wait_bursts(4);
    for (int i = 0; i < 4; i++) begin
      expect_eq($sformatf("burst %0d addr", i), addr_t'(START + 8 * i), u_model.wr_log[i]);
      expect_eq($sformatf("burst %0d data", i),
                {words[4*i+3], words[4*i+2], words[4*i+1], words[4*i]},
                u_model.mem[addr_t'(START + 8 * i)]);
    end
    finish_test("upload");

    wait_reads(4);
    wait_cmd_en(1'b0);
    check_replay(0);
    finish_test("replay");

    coef_high = 1'b1;
    send_word(pixel(1'b0, 1'b0)); // frame gap starts the next replay
    wait_cmd_en(1'b1);
    wait_cmd_en(1'b0);
    held = u_model.rd_log.size();
    for (int i = 0; i < 10; i++) begin
      @(negedge CLK);
      expect_eq("throttled en", 0, app_cmd.en);
    end
    expect_eq("throttled reads", held, u_model.rd_log.size());
    @(posedge CLK);
    #2;
    coef_high = 1'b0;
    wait_reads(8);
    wait_cmd_en(1'b0);
    check_replay(4);
    finish_test("throttle");

    for (int i = 0; i < 4; i++) send_word(pixel(1'b1, 1'b1)); // first line
    send_word(pixel(1'b1, 1'b0)); // line gap
    for (int i = 0; i < 3; i++) send_word(pixel(1'b1, 1'b1)); // second line
    wait_pixels_drained();
    // first lval word is column 0, then +2 per word
    expect_eq("pixel row", 1, pix_pos.row);
    expect_eq("pixel col", 4, pix_pos.col);
    expect_eq("pixel frame", 0, pix_pos.frame);
    send_word(pixel(1'b0, 1'b0)); // fval falls
    wait_pixels_drained();
    expect_eq("frame count", 1, pix_pos.frame);
    expect_eq("row at frame end", 1, pix_pos.row);
    wait_reads(12);
    wait_cmd_en(1'b0);
    check_replay(8);
    finish_test("pixel timing");

    // controller parked in interframe, nothing pops the dram queue
    for (int i = 0; i < 16; i++) send_word(32'h0000_0103 + (i << 8));
    wait_dram_full();
    pc_msg_pending = 1'b1;
    pc_msg = pixel(1'b1, 1'b0);
    for (int i = 0; i < 8; i++) begin
      @(negedge CLK);
      expect_eq("ack while full", 0, pc_msg_ack);
    end
    @(posedge CLK);
    #2;
    pc_msg_pending = 1'b0;
    expect_eq("error output", 0, error);
    finish_test("queue full");

    $display("tests run %0d, checks %0d, failures %0d", tests, checks, failures());
    if (failures() == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- vlog.f
source/msg_pkg.sv
source/dram_pkg.sv
source/msg_fifo.sv
source/pc_msg_router.sv
source/dram_coef_ctrl.sv
source/coef_steer.sv
source/pixel_timing.sv
source/pattern_top.sv
tb/pattern_assertions.sv
tb/tb_dram_model.sv
tb/tb_pattern_top.sv

//--- Bender.yml
package:
  name: pattern_top

sources:
  - files:
      - source/msg_pkg.sv
      - source/dram_pkg.sv
      - source/msg_fifo.sv
      - source/pc_msg_router.sv
      - source/dram_coef_ctrl.sv
      - source/coef_steer.sv
      - source/pixel_timing.sv
      - source/pattern_top.sv
  - target: test
    files:
      - tb/pattern_assertions.sv
      - tb/tb_dram_model.sv
      - tb/tb_pattern_top.sv
